// ==== rtl/rp_pkg.sv ====
// shared constants of the two-channel analog path
// sample and gain formats, pdm setup and the axi4-lite register map
package rp_pkg;

  // sample formats
  localparam int unsigned SMP_W = 14;
  localparam int unsigned PIN_W = 16;
  localparam logic signed [SMP_W-1:0] SMP_MAX = {1'b0, {(SMP_W-1){1'b1}}};
  localparam logic signed [SMP_W-1:0] SMP_MIN = {1'b1, {(SMP_W-1){1'b0}}};
  localparam int unsigned NUM_CH = 2;

  // calibration, gain is fixed point with 14 fraction bits
  localparam int unsigned GAIN_W = 16;
  localparam int unsigned GAIN_FRAC = 14;
  localparam logic [GAIN_W-1:0] GAIN_UNITY = 16'h4000;
  localparam int unsigned CAL_LAT = 2;

  // pulse density outputs
  localparam int unsigned PDM_CHN = 4;
  localparam int unsigned PDM_W = 8;
  localparam int unsigned PDM_RANGE = 255;

  // axi4-lite bus
  localparam int unsigned AXIL_AW = 8;
  localparam int unsigned AXIL_DW = 32;
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // register byte addresses
  localparam logic [AXIL_AW-1:0] REG_MUX = 8'h00;
  localparam logic [AXIL_AW-1:0] REG_ADC_GAIN0 = 8'h04;
  localparam logic [AXIL_AW-1:0] REG_ADC_OFFS0 = 8'h08;
  localparam logic [AXIL_AW-1:0] REG_ADC_GAIN1 = 8'h0C;
  localparam logic [AXIL_AW-1:0] REG_ADC_OFFS1 = 8'h10;
  localparam logic [AXIL_AW-1:0] REG_DAC_GAIN0 = 8'h14;
  localparam logic [AXIL_AW-1:0] REG_DAC_OFFS0 = 8'h18;
  localparam logic [AXIL_AW-1:0] REG_DAC_GAIN1 = 8'h1C;
  localparam logic [AXIL_AW-1:0] REG_DAC_OFFS1 = 8'h20;
  localparam logic [AXIL_AW-1:0] REG_PDM0 = 8'h24;
  localparam logic [AXIL_AW-1:0] REG_PDM1 = 8'h28;
  localparam logic [AXIL_AW-1:0] REG_PDM2 = 8'h2C;
  localparam logic [AXIL_AW-1:0] REG_PDM3 = 8'h30;

endpackage

// ==== rtl/axil_if.sv ====
// axi4-lite bundle between the top level and the register block
// master side is driven from the top pins, the slave side by calib_regs
`timescale 1ns/10ps

interface axil_if #(
  parameter int unsigned AW = 8,
  parameter int unsigned DW = 32
);

  // write address, write data, write response
  logic [AW-1:0]   awaddr;
  logic            awvalid, awready;
  logic [DW-1:0]   wdata;
  logic [DW/8-1:0] wstrb;
  logic            wvalid, wready;
  logic [1:0]      bresp;
  logic            bvalid, bready;
  // read address, read data
  logic [AW-1:0]   araddr;
  logic            arvalid, arready;
  logic [DW-1:0]   rdata;
  logic [1:0]      rresp;
  logic            rvalid, rready;

  modport master (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

  modport slave (
    input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid
  );

endinterface

// ==== rtl/linear_cal.sv ====
// gain and offset correction of one sample stream, two cycles deep
// result = sat((dat * gain) >>> 14 + offs)
`timescale 1ns/10ps

module linear_cal import rp_pkg::*; (
  input  logic                    adc_clk_i,
  input  logic                    top_rst_i,
  input  logic signed [SMP_W-1:0] dat_i,
  input  logic                    vld_i,
  input  logic signed [GAIN_W-1:0] gain_i,
  input  logic signed [SMP_W-1:0] offs_i,
  output logic signed [SMP_W-1:0] dat_o,
  output logic                    vld_o
);

  // full product keeps every bit
  logic signed [SMP_W+GAIN_W-1:0] prod_q;
  logic                           vld_q;
  logic signed [SMP_W+GAIN_W-1:0] prod_sh;
  // one extra bit so the offset sum cannot wrap
  logic signed [SMP_W+GAIN_W:0]   sum;
  logic signed [SMP_W-1:0]        sat;

  // stage one, multiply
  always_ff @(posedge adc_clk_i) begin
    prod_q <= dat_i * gain_i;
  end

  // drop fraction bits, add offset, clip to sample range
  assign prod_sh = prod_q >>> GAIN_FRAC;
  assign sum     = prod_sh + offs_i;

  always_comb begin
    if (sum > SMP_MAX) begin
      sat = SMP_MAX;
    end else if (sum < SMP_MIN) begin
      sat = SMP_MIN;
    end else begin
      sat = sum[SMP_W-1:0];
    end
  end

  // stage two, registered result
  always_ff @(posedge adc_clk_i) begin
    dat_o <= sat;
  end

  // valid follows the data through both stages
  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      vld_q <= 1'b0;
      vld_o <= 1'b0;
    end else begin
      vld_q <= vld_i;
      vld_o <= vld_q;
    end
  end

endmodule

// ==== rtl/adc_front.sv ====
// one adc channel, pin capture and code conversion, then calibration
// loopback replaces the pin sample with the calibrated dac sample
`timescale 1ns/10ps

module adc_front import rp_pkg::*; (
  input  logic                     adc_clk_i,
  input  logic                     top_rst_i,
  input  logic [PIN_W-1:0]         pin_i,
  input  logic                     loop_i,
  input  logic signed [SMP_W-1:0]  lb_dat_i,
  input  logic                     lb_vld_i,
  input  logic signed [GAIN_W-1:0] gain_i,
  input  logic signed [SMP_W-1:0]  offs_i,
  output logic signed [SMP_W-1:0]  dat_o,
  output logic                     vld_o
);

  logic signed [SMP_W-1:0] pin_smp;
  logic signed [SMP_W-1:0] sel_dat;
  logic                    sel_vld;

  // capture pins, two low bits are reserved
  // keep the msb, invert the rest for two's complement
  always_ff @(posedge adc_clk_i) begin
    pin_smp <= {pin_i[PIN_W-1], ~pin_i[PIN_W-2:2]};
  end

  // loopback skips the capture stage
  assign sel_dat = loop_i ? lb_dat_i : pin_smp;
  // pins always carry a sample
  assign sel_vld = loop_i ? lb_vld_i : 1'b1;

  linear_cal lin_cal (
    .adc_clk_i (adc_clk_i),
    .top_rst_i (top_rst_i),
    .dat_i     (sel_dat),
    .vld_i     (sel_vld),
    .gain_i    (gain_i),
    .offs_i    (offs_i),
    .dat_o     (dat_o),
    .vld_o     (vld_o)
  );

endmodule

// ==== rtl/dac_back.sv ====
// one dac channel, calibration then output coding
// calibrated sample is also handed to the adc side for loopback
`timescale 1ns/10ps

module dac_back import rp_pkg::*; (
  input  logic                     adc_clk_i,
  input  logic                     top_rst_i,
  input  logic signed [SMP_W-1:0]  dat_i,
  input  logic                     vld_i,
  input  logic signed [GAIN_W-1:0] gain_i,
  input  logic signed [SMP_W-1:0]  offs_i,
  output logic signed [SMP_W-1:0]  cal_dat_o,
  output logic                     cal_vld_o,
  output logic [SMP_W-1:0]         dac_dat_o,
  output logic                     dac_vld_o
);

  linear_cal lin_cal (
    .adc_clk_i (adc_clk_i),
    .top_rst_i (top_rst_i),
    .dat_i     (dat_i),
    .vld_i     (vld_i),
    .gain_i    (gain_i),
    .offs_i    (offs_i),
    .dat_o     (cal_dat_o),
    .vld_o     (cal_vld_o)
  );

  // inverted offset binary, msb kept
  // converter wants the negative slope
  always_ff @(posedge adc_clk_i) begin
    dac_dat_o <= {cal_dat_o[SMP_W-1], ~cal_dat_o[SMP_W-2:0]};
  end

  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      dac_vld_o <= 1'b0;
    end else begin
      dac_vld_o <= cal_vld_o;
    end
  end

endmodule

// ==== rtl/calib_regs.sv ====
// axi4-lite register block for calibration, loopback and pdm levels
// one write and one read in flight, out-of-map accesses get slverr
`timescale 1ns/10ps

module calib_regs import rp_pkg::*; (
  input  logic                          adc_clk_i,
  input  logic                          top_rst_i,
  axil_if.slave                         bus,
  output logic [NUM_CH-1:0]             mux_loop_o,
  output logic [NUM_CH-1:0][GAIN_W-1:0] adc_gain_o,
  output logic [NUM_CH-1:0][SMP_W-1:0]  adc_offs_o,
  output logic [NUM_CH-1:0][GAIN_W-1:0] dac_gain_o,
  output logic [NUM_CH-1:0][SMP_W-1:0]  dac_offs_o,
  output logic [PDM_CHN-1:0][PDM_W-1:0] pdm_lvl_o
);

  // write side state
  logic                 aw_full, w_full;
  logic                 aw_full_d, w_full_d, bvalid_d;
  logic                 aw_hs, w_hs, wr_go, ar_hs;
  logic [AXIL_AW-1:0]   awaddr_q;
  logic [AXIL_DW-1:0]   wdata_q;
  logic [AXIL_DW/8-1:0] wstrb_q;
  logic [AXIL_DW-1:0]   wr_mask, wr_word;

  // word aligned and inside the map
  function automatic logic reg_hit(input logic [AXIL_AW-1:0] addr);
    return (addr[1:0] == 2'b00) && (addr <= REG_PDM3);
  endfunction

  // readback word, unused bits zero
  function automatic logic [AXIL_DW-1:0] reg_rd(input logic [AXIL_AW-1:0] addr);
    logic [AXIL_DW-1:0] word;
    word = '0;
    case (addr)
      REG_MUX:       word[NUM_CH-1:0] = mux_loop_o;
      REG_ADC_GAIN0: word[GAIN_W-1:0] = adc_gain_o[0];
      REG_ADC_OFFS0: word[SMP_W-1:0]  = adc_offs_o[0];
      REG_ADC_GAIN1: word[GAIN_W-1:0] = adc_gain_o[1];
      REG_ADC_OFFS1: word[SMP_W-1:0]  = adc_offs_o[1];
      REG_DAC_GAIN0: word[GAIN_W-1:0] = dac_gain_o[0];
      REG_DAC_OFFS0: word[SMP_W-1:0]  = dac_offs_o[0];
      REG_DAC_GAIN1: word[GAIN_W-1:0] = dac_gain_o[1];
      REG_DAC_OFFS1: word[SMP_W-1:0]  = dac_offs_o[1];
      REG_PDM0:      word[PDM_W-1:0]  = pdm_lvl_o[0];
      REG_PDM1:      word[PDM_W-1:0]  = pdm_lvl_o[1];
      REG_PDM2:      word[PDM_W-1:0]  = pdm_lvl_o[2];
      REG_PDM3:      word[PDM_W-1:0]  = pdm_lvl_o[3];
      default:       word = '0;
    endcase
    return word;
  endfunction

  ////////////////////////////////////////////////////////////
  // write channel
  ////////////////////////////////////////////////////////////

  assign aw_hs = bus.awvalid & bus.awready;
  assign w_hs  = bus.wvalid & bus.wready;
  // commit once address and data are both held
  assign wr_go = aw_full & w_full;

  assign aw_full_d = ~wr_go & (aw_full | aw_hs);
  assign w_full_d  = ~wr_go & (w_full | w_hs);
  assign bvalid_d  = wr_go | (bus.bvalid & ~bus.bready);

  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      aw_full     <= 1'b0;
      w_full      <= 1'b0;
      bus.bvalid  <= 1'b0;
      bus.awready <= 1'b0;
      bus.wready  <= 1'b0;
    end else begin
      aw_full     <= aw_full_d;
      w_full      <= w_full_d;
      bus.bvalid  <= bvalid_d;
      // no new write while a response is pending
      bus.awready <= ~aw_full_d & ~bvalid_d;
      bus.wready  <= ~w_full_d & ~bvalid_d;
    end
  end

  // merge strobed bytes into the current value
  always_comb begin
    for (int b = 0; b < AXIL_DW/8; b++) begin
      wr_mask[8*b +: 8] = {8{wstrb_q[b]}};
    end
    wr_word = (reg_rd(awaddr_q) & ~wr_mask) | (wdata_q & wr_mask);
  end

  ////////////////////////////////////////////////////////////
  // read channel
  ////////////////////////////////////////////////////////////

  assign ar_hs = bus.arvalid & bus.arready;

  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      bus.arready <= 1'b1;
      bus.rvalid  <= 1'b0;
    end else if (ar_hs) begin
      bus.arready <= 1'b0;
      bus.rvalid  <= 1'b1;
    end else if (bus.rvalid && bus.rready) begin
      bus.arready <= 1'b1;
      bus.rvalid  <= 1'b0;
    end
  end

  // captured payload and responses
  always_ff @(posedge adc_clk_i) begin
    if (aw_hs) begin
      awaddr_q <= bus.awaddr;
    end
    if (w_hs) begin
      wdata_q <= bus.wdata;
      wstrb_q <= bus.wstrb;
    end
    if (wr_go) begin
      bus.bresp <= reg_hit(awaddr_q) ? RESP_OKAY : RESP_SLVERR;
    end
    if (ar_hs) begin
      bus.rdata <= reg_rd(bus.araddr);
      bus.rresp <= reg_hit(bus.araddr) ? RESP_OKAY : RESP_SLVERR;
    end
  end

  ////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
    if (top_rst_i) begin
      mux_loop_o <= '0;
      adc_gain_o <= {NUM_CH{GAIN_UNITY}};
      adc_offs_o <= '0;
      dac_gain_o <= {NUM_CH{GAIN_UNITY}};
      dac_offs_o <= '0;
      pdm_lvl_o  <= '0;
    end else if (wr_go) begin
      // out-of-map addresses fall through untouched
      case (awaddr_q)
        REG_MUX:       mux_loop_o    <= wr_word[NUM_CH-1:0];
        REG_ADC_GAIN0: adc_gain_o[0] <= wr_word[GAIN_W-1:0];
        REG_ADC_OFFS0: adc_offs_o[0] <= wr_word[SMP_W-1:0];
        REG_ADC_GAIN1: adc_gain_o[1] <= wr_word[GAIN_W-1:0];
        REG_ADC_OFFS1: adc_offs_o[1] <= wr_word[SMP_W-1:0];
        REG_DAC_GAIN0: dac_gain_o[0] <= wr_word[GAIN_W-1:0];
        REG_DAC_OFFS0: dac_offs_o[0] <= wr_word[SMP_W-1:0];
        REG_DAC_GAIN1: dac_gain_o[1] <= wr_word[GAIN_W-1:0];
        REG_DAC_OFFS1: dac_offs_o[1] <= wr_word[SMP_W-1:0];
        REG_PDM0:      pdm_lvl_o[0]  <= wr_word[PDM_W-1:0];
        REG_PDM1:      pdm_lvl_o[1]  <= wr_word[PDM_W-1:0];
        REG_PDM2:      pdm_lvl_o[2]  <= wr_word[PDM_W-1:0];
        REG_PDM3:      pdm_lvl_o[3]  <= wr_word[PDM_W-1:0];
        default: ;
      endcase
    end
  end

endmodule

// ==== rtl/pdm_dac.sv ====
// first-order pulse density modulators, one per slow analog output
// ones per 255 cycles equal the programmed level
`timescale 1ns/10ps

module pdm_dac import rp_pkg::*; (
  input  logic                          adc_clk_i,
  input  logic                          top_rst_i,
  input  logic [PDM_CHN-1:0][PDM_W-1:0] lvl_i,
  output logic [PDM_CHN-1:0]            pdm_o
);

  for (genvar c = 0; c < PDM_CHN; c++) begin : g_chn

    // accumulator stays below PDM_RANGE
    logic [PDM_W-1:0] acc;
    logic [PDM_W:0]   sum;
    logic             pdm_q;

    assign sum = acc + lvl_i[c];

    // overflow emits a one and wraps by the period
    always_ff @(posedge adc_clk_i, posedge top_rst_i) begin
      if (top_rst_i) begin
        acc   <= '0;
        pdm_q <= 1'b0;
      end else if (sum >= PDM_RANGE) begin
        acc   <= PDM_W'(sum - PDM_RANGE);
        pdm_q <= 1'b1;
      end else begin
        acc   <= PDM_W'(sum);
        pdm_q <= 1'b0;
      end
    end

    assign pdm_o[c] = pdm_q;

  end

endmodule

// ==== rtl/rp_analog_top.sv ====
// analog path top level in the adc_clk domain
// bus pins go into the axi4-lite bundle, channels hang off the register block
`timescale 1ns/10ps

module rp_analog_top import rp_pkg::*; (
  input  logic                            adc_clk,
  input  logic                            top_rst,
  // sample streams
  input  logic [NUM_CH-1:0][PIN_W-1:0]    adc_dat_i,
  input  logic signed [NUM_CH-1:0][SMP_W-1:0] gen_dat_i,
  input  logic [NUM_CH-1:0]               gen_vld_i,
  output logic signed [NUM_CH-1:0][SMP_W-1:0] adc_dat_o,
  output logic [NUM_CH-1:0]               adc_vld_o,
  output logic [NUM_CH-1:0][SMP_W-1:0]    dac_dat_o,
  output logic [NUM_CH-1:0]               dac_vld_o,
  output logic [PDM_CHN-1:0]              dac_pwm_o,
  // axi4-lite slave
  input  logic [AXIL_AW-1:0]              s_axil_awaddr_i,
  input  logic                            s_axil_awvalid_i,
  output logic                            s_axil_awready_o,
  input  logic [AXIL_DW-1:0]              s_axil_wdata_i,
  input  logic [AXIL_DW/8-1:0]            s_axil_wstrb_i,
  input  logic                            s_axil_wvalid_i,
  output logic                            s_axil_wready_o,
  output logic [1:0]                      s_axil_bresp_o,
  output logic                            s_axil_bvalid_o,
  input  logic                            s_axil_bready_i,
  input  logic [AXIL_AW-1:0]              s_axil_araddr_i,
  input  logic                            s_axil_arvalid_i,
  output logic                            s_axil_arready_o,
  output logic [AXIL_DW-1:0]              s_axil_rdata_o,
  output logic [1:0]                      s_axil_rresp_o,
  output logic                            s_axil_rvalid_o,
  input  logic                            s_axil_rready_i
);

  // configuration from the register block
  logic [NUM_CH-1:0]             mux_loop;
  logic [NUM_CH-1:0][GAIN_W-1:0] adc_gain, dac_gain;
  logic [NUM_CH-1:0][SMP_W-1:0]  adc_offs, dac_offs;
  logic [PDM_CHN-1:0][PDM_W-1:0] pdm_lvl;
  // calibrated dac samples for loopback
  logic [NUM_CH-1:0][SMP_W-1:0]  dac_cal_dat;
  logic [NUM_CH-1:0]             dac_cal_vld;

  ////////////////////////////////////////////////////////////
  // register bus
  ////////////////////////////////////////////////////////////

  axil_if #(.AW(AXIL_AW), .DW(AXIL_DW)) axil ();

  assign axil.awaddr  = s_axil_awaddr_i;
  assign axil.awvalid = s_axil_awvalid_i;
  assign axil.wdata   = s_axil_wdata_i;
  assign axil.wstrb   = s_axil_wstrb_i;
  assign axil.wvalid  = s_axil_wvalid_i;
  assign axil.bready  = s_axil_bready_i;
  assign axil.araddr  = s_axil_araddr_i;
  assign axil.arvalid = s_axil_arvalid_i;
  assign axil.rready  = s_axil_rready_i;

  assign s_axil_awready_o = axil.awready;
  assign s_axil_wready_o  = axil.wready;
  assign s_axil_bresp_o   = axil.bresp;
  assign s_axil_bvalid_o  = axil.bvalid;
  assign s_axil_arready_o = axil.arready;
  assign s_axil_rdata_o   = axil.rdata;
  assign s_axil_rresp_o   = axil.rresp;
  assign s_axil_rvalid_o  = axil.rvalid;

  calib_regs regs (
    .adc_clk_i  (adc_clk),
    .top_rst_i  (top_rst),
    .bus        (axil.slave),
    .mux_loop_o (mux_loop),
    .adc_gain_o (adc_gain),
    .adc_offs_o (adc_offs),
    .dac_gain_o (dac_gain),
    .dac_offs_o (dac_offs),
    .pdm_lvl_o  (pdm_lvl)
  );

  ////////////////////////////////////////////////////////////
  // channels
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NUM_CH; i++) begin : g_ch

    dac_back dac (
      .adc_clk_i (adc_clk),
      .top_rst_i (top_rst),
      .dat_i     (gen_dat_i[i]),
      .vld_i     (gen_vld_i[i]),
      .gain_i    (dac_gain[i]),
      .offs_i    (dac_offs[i]),
      .cal_dat_o (dac_cal_dat[i]),
      .cal_vld_o (dac_cal_vld[i]),
      .dac_dat_o (dac_dat_o[i]),
      .dac_vld_o (dac_vld_o[i])
    );

    // same channel dac feeds the loopback input
    adc_front adc (
      .adc_clk_i (adc_clk),
      .top_rst_i (top_rst),
      .pin_i     (adc_dat_i[i]),
      .loop_i    (mux_loop[i]),
      .lb_dat_i  (dac_cal_dat[i]),
      .lb_vld_i  (dac_cal_vld[i]),
      .gain_i    (adc_gain[i]),
      .offs_i    (adc_offs[i]),
      .dat_o     (adc_dat_o[i]),
      .vld_o     (adc_vld_o[i])
    );

  end

  // slow analog outputs
  pdm_dac pdm (
    .adc_clk_i (adc_clk),
    .top_rst_i (top_rst),
    .lvl_i     (pdm_lvl),
    .pdm_o     (dac_pwm_o)
  );

endmodule

// ==== dv/tb_top.sv ====
// testbench for the two-channel analog path
// drives the bus, sample streams and pins of rp_analog_top and checks them
// against reference models built from the calibration and coding rules
`timescale 1ns/10ps

module tb_top import rp_pkg::*; ();

  localparam int CLK_PERIOD = 10;
  localparam int STREAM_LEN = 200;
  // about 100 bus accesses, five streams and one pdm window
  localparam int RUN_CYCLES = 100 * 8 + 5 * (STREAM_LEN + 8) + 2 * PDM_RANGE;
  localparam int NUM_REGS = 13;

  logic adc_clk, top_rst;
  logic [NUM_CH-1:0][PIN_W-1:0] adc_dat_i;
  logic signed [NUM_CH-1:0][SMP_W-1:0] gen_dat_i, adc_dat_o;
  logic [NUM_CH-1:0] gen_vld_i, adc_vld_o, dac_vld_o;
  logic [NUM_CH-1:0][SMP_W-1:0] dac_dat_o;
  logic [PDM_CHN-1:0] dac_pwm_o;
  logic [AXIL_AW-1:0] awaddr, araddr;
  logic [AXIL_DW-1:0] wdata, rdata;
  logic [3:0] wstrb;
  logic [1:0] bresp, rresp;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;

  int seed = 32256;
  int errors, checks, tests, test_err_base;
  // expected register contents by byte address / 4
  logic [31:0] reg_mirror [NUM_REGS];
  // input history per channel with the newest at index 0
  logic [PIN_W-1:0] pin_h [NUM_CH][4];
  logic [SMP_W-1:0] gen_h [NUM_CH][4];
  logic             vld_h [NUM_CH][4];

  rp_analog_top dut (
    .adc_clk (adc_clk), .top_rst (top_rst),
    .adc_dat_i (adc_dat_i), .gen_dat_i (gen_dat_i), .gen_vld_i (gen_vld_i),
    .adc_dat_o (adc_dat_o), .adc_vld_o (adc_vld_o),
    .dac_dat_o (dac_dat_o), .dac_vld_o (dac_vld_o), .dac_pwm_o (dac_pwm_o),
    .s_axil_awaddr_i (awaddr), .s_axil_awvalid_i (awvalid), .s_axil_awready_o (awready),
    .s_axil_wdata_i (wdata), .s_axil_wstrb_i (wstrb), .s_axil_wvalid_i (wvalid),
    .s_axil_wready_o (wready), .s_axil_bresp_o (bresp), .s_axil_bvalid_o (bvalid),
    .s_axil_bready_i (bready), .s_axil_araddr_i (araddr), .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready), .s_axil_rdata_o (rdata), .s_axil_rresp_o (rresp),
    .s_axil_rvalid_o (rvalid), .s_axil_rready_i (rready)
  );

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////
  // bus protocol assertions
  ////////////////////////////////////////////////////////////

  // responses stay up until taken
  assert property (@(posedge adc_clk) disable iff (top_rst) bvalid && !bready |=> bvalid)
    else begin
      errors++;
      $display("write response dropped before it was accepted");
    end
  assert property (@(posedge adc_clk) disable iff (top_rst)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      errors++;
      $display("read response dropped or changed before it was accepted");
    end
  // one read at a time
  assert property (@(posedge adc_clk) disable iff (top_rst) arready != rvalid)
    else begin
      errors++;
      $display("read address accepted while a read response is pending");
    end
  // no new write while a response waits
  assert property (@(posedge adc_clk) disable iff (top_rst) bvalid |-> !awready && !wready)
    else begin
      errors++;
      $display("write accepted while a write response is pending");
    end

  ////////////////////////////////////////////////////////////
  // reference models
  ////////////////////////////////////////////////////////////

  // pins 15..2 with the msb kept and the rest inverted
  function automatic logic [SMP_W-1:0] pin_model(input logic [PIN_W-1:0] pin);
    return {pin[15], ~pin[14:2]};
  endfunction

  // gain with 14 fraction bits then offset and clipping to 14-bit signed
  function automatic logic [SMP_W-1:0] cal_model(input logic [SMP_W-1:0] x,
                                                 input logic [15:0] g,
                                                 input logic [SMP_W-1:0] o);
    int p;
    int s;
    p = $signed(x) * $signed(g);
    s = (p >>> 14) + $signed(o);
    if (s > 8191) s = 8191;
    else if (s < -8192) s = -8192;
    return s[SMP_W-1:0];
  endfunction

  function automatic logic [SMP_W-1:0] dac_code(input logic [SMP_W-1:0] s);
    return {s[13], ~s[12:0]};
  endfunction

  // implemented bits per register
  function automatic logic [31:0] field_mask(input int idx);
    if (idx == 0) return 32'h3;
    else if (idx >= 9) return 32'hFF;
    else if (idx % 2 == 1) return 32'hFFFF;
    else return 32'h3FFF;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("Error: %s got %h expected %h", name, got, exp);
      end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %s finished with %0d errors", name, errors - test_err_base);
    test_err_base = errors;
  endtask

  ////////////////////////////////////////////////////////////
  // bus tasks entered and left on a falling edge
  ////////////////////////////////////////////////////////////

  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    bit aw_done;
    bit w_done;
    aw_done = 0;
    w_done = 0;
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    while (!(aw_done && w_done)) begin
      // ready seen now means a transfer at the next rising edge
      if (awvalid && awready) aw_done = 1;
      if (wvalid && wready) w_done = 1;
      @(negedge adc_clk);
      if (aw_done) awvalid = 1'b0;
      if (w_done) wvalid = 1'b0;
    end
    while (!bvalid) @(negedge adc_clk);
    // response waits one cycle before it is taken
    @(negedge adc_clk);
    resp = bresp;
    bready = 1'b1;
    @(negedge adc_clk);
    bready = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    araddr = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge adc_clk);
    @(negedge adc_clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge adc_clk);
    // response waits one cycle before it is taken
    @(negedge adc_clk);
    data = rdata;
    resp = rresp;
    rready = 1'b1;
    @(negedge adc_clk);
    rready = 1'b0;
  endtask

  // byte-strobed write to a mapped register and its mirror
  task automatic write_masked(input int idx, input logic [31:0] data, input logic [3:0] strb);
    logic [1:0] resp;
    logic [31:0] bmask;
    bmask = '0;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) bmask[8*b +: 8] = 8'hFF;
    end
    bus_write(8'(idx * 4), data, strb, resp);
    check_eq($sformatf("bresp at %h", idx * 4), 32'(resp), 32'(RESP_OKAY));
    reg_mirror[idx] = ((reg_mirror[idx] & ~bmask) | (data & bmask)) & field_mask(idx);
  endtask

  task automatic check_all_regs();
    logic [31:0] data;
    logic [1:0] resp;
    for (int idx = 0; idx < NUM_REGS; idx++) begin
      bus_read(8'(idx * 4), data, resp);
      check_eq($sformatf("rdata at %h", idx * 4), data, reg_mirror[idx]);
      check_eq($sformatf("rresp at %h", idx * 4), 32'(resp), 32'(RESP_OKAY));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // sample streams
  ////////////////////////////////////////////////////////////

  // random pins and generator data checked after a 4-cycle warm-up
  task automatic run_stream(input int n);
    logic [SMP_W-1:0] exp;
    logic exp_vld;
    logic [15:0] ag, dg;
    logic [SMP_W-1:0] ao, dof;
    for (int k = 0; k < n + 4; k++) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        ag = reg_mirror[1 + 2*ch][15:0];
        ao = reg_mirror[2 + 2*ch][SMP_W-1:0];
        dg = reg_mirror[5 + 2*ch][15:0];
        dof = reg_mirror[6 + 2*ch][SMP_W-1:0];
        if (k >= 4) begin
          // dac output 3 cycles behind its input
          check_eq($sformatf("dac_vld_o[%0d]", ch), 32'(dac_vld_o[ch]), 32'(vld_h[ch][2]));
          if (vld_h[ch][2]) begin
            exp = dac_code(cal_model(gen_h[ch][2], dg, dof));
            check_eq($sformatf("dac_dat_o[%0d]", ch), 32'(dac_dat_o[ch]), 32'(exp));
          end
          // loopback adds one cycle over the pin path
          if (reg_mirror[0][ch]) begin
            exp_vld = vld_h[ch][3];
            exp = cal_model(cal_model(gen_h[ch][3], dg, dof), ag, ao);
          end else begin
            exp_vld = 1'b1;
            exp = cal_model(pin_model(pin_h[ch][2]), ag, ao);
          end
          check_eq($sformatf("adc_vld_o[%0d]", ch), 32'(adc_vld_o[ch]), 32'(exp_vld));
          if (exp_vld) begin
            check_eq($sformatf("adc_dat_o[%0d]", ch), 32'(adc_dat_o[ch]), 32'(exp));
          end
        end
        adc_dat_i[ch] = 16'($random(seed));
        gen_dat_i[ch] = 14'($random(seed));
        gen_vld_i[ch] = 1'($random(seed));
        for (int j = 3; j > 0; j--) begin
          pin_h[ch][j] = pin_h[ch][j-1];
          gen_h[ch][j] = gen_h[ch][j-1];
          vld_h[ch][j] = vld_h[ch][j-1];
        end
        pin_h[ch][0] = adc_dat_i[ch];
        gen_h[ch][0] = gen_dat_i[ch];
        vld_h[ch][0] = gen_vld_i[ch];
      end
      @(negedge adc_clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_registers();
    logic [31:0] data;
    logic [1:0] resp;
    check_all_regs();
    for (int idx = 0; idx < NUM_REGS; idx++) begin
      write_masked(idx, 32'($random(seed)), 4'($random(seed)));
    end
    check_all_regs();
    // out-of-map access leaves every register as it was
    bus_write(8'h40, 32'hFFFF_FFFF, 4'hF, resp);
    check_eq("bresp at 40", 32'(resp), 32'(RESP_SLVERR));
    bus_read(8'h40, data, resp);
    check_eq("rdata at 40", data, 32'h0);
    check_eq("rresp at 40", 32'(resp), 32'(RESP_SLVERR));
    check_all_regs();
    finish_test("registers");
  endtask

  task automatic test_pdm();
    int lvl [PDM_CHN] = '{0, 1, 128, 255};
    int ones [PDM_CHN];
    for (int c = 0; c < PDM_CHN; c++) begin
      write_masked(9 + c, 32'(lvl[c]), 4'hF);
      ones[c] = 0;
    end
    repeat (PDM_RANGE) begin
      for (int c = 0; c < PDM_CHN; c++) begin
        if (dac_pwm_o[c]) ones[c]++;
      end
      @(negedge adc_clk);
    end
    for (int c = 0; c < PDM_CHN; c++) begin
      check_eq($sformatf("dac_pwm_o[%0d] ones", c), 32'(ones[c]), 32'(lvl[c]));
    end
    finish_test("pdm density");
  endtask

  // watchdog at twice the expected run length
  initial begin
    #(2 * RUN_CYCLES * CLK_PERIOD);
    $display("timeout, the run did not finish within %0d cycles", 2 * RUN_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin
    adc_clk = 1'b0;
    top_rst = 1'b1;
    adc_dat_i = '0;
    gen_dat_i = '0;
    gen_vld_i = '0;
    {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
    {araddr, arvalid, rready} = '0;
    for (int idx = 0; idx < NUM_REGS; idx++) begin
      reg_mirror[idx] = (idx >= 1 && idx <= 8 && idx % 2 == 1) ? 32'h4000 : 32'h0;
    end
    repeat (3) @(negedge adc_clk);
    // control outputs while reset is still held
    check_eq("adc_vld_o", 32'(adc_vld_o), 32'h0);
    check_eq("dac_vld_o", 32'(dac_vld_o), 32'h0);
    check_eq("dac_pwm_o", 32'(dac_pwm_o), 32'h0);
    check_eq("bvalid/rvalid", 32'({bvalid, rvalid}), 32'h0);
    check_eq("awready/wready", 32'({awready, wready}), 32'h0);
    check_eq("arready", 32'(arready), 32'h1);
    top_rst = 1'b0;
    @(negedge adc_clk);
    test_registers();
    // pins at unity then full-scale gains of both signs
    write_masked(0, 32'h0, 4'hF);
    for (int idx = 1; idx <= 8; idx++) begin
      write_masked(idx, (idx % 2 == 1) ? 32'h4000 : 32'h0, 4'hF);
    end
    run_stream(STREAM_LEN);
    write_masked(1, 32'h7FFF, 4'hF);
    write_masked(3, 32'h8000, 4'hF);
    write_masked(2, 32'($random(seed)), 4'hF);
    write_masked(4, 32'($random(seed)), 4'hF);
    run_stream(STREAM_LEN);
    finish_test("adc calibration");
    for (int idx = 5; idx <= 8; idx++) begin
      write_masked(idx, 32'($random(seed)), 4'hF);
    end
    run_stream(STREAM_LEN);
    finish_test("dac path");
    for (int idx = 1; idx <= 4; idx++) begin
      write_masked(idx, 32'($random(seed)), 4'hF);
    end
    write_masked(0, 32'h1, 4'hF);
    run_stream(STREAM_LEN);
    write_masked(0, 32'h2, 4'hF);
    run_stream(STREAM_LEN / 2);
    finish_test("loopback");
    test_pdm();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/rp_pkg.sv
rtl/axil_if.sv
rtl/linear_cal.sv
rtl/adc_front.sv
rtl/dac_back.sv
rtl/calib_regs.sv
rtl/pdm_dac.sv
rtl/rp_analog_top.sv
dv/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f compile.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

# the run passes only if the pass line was printed
echo "$out" | grep -qx "All checks passed"
